// File: project.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/bus_arbiter.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/mem_wb_unit.sv
rtl/cpu_top.sv
tests/tb_cpu_assert.sv
tests/tb_cpu.sv

// File: tests/cpu_patterns.txt
# P word: program word, loaded from word 0 upward
# W pc reg data: expected writeback in order; M addr data: final memory word
# ALU chain with forwarding from memory and writeback
P 3c011234
P 34215678
P 24020010
P 00221821
P 00612023
P 2405ffff
P 00a4302a
P 00253824
P 00c44025
P 24090400
# sw then lw of the same word, load-use right after
P ad210000
P 8d2a0000
P 01425821
P ad2b0004
# write to register zero, then a read of it
P 24000005
P 00026021
# taken beq over two words, then a bne that falls through
P 10c60002
P 240d0bad
P 240e0bad
P 14440005
P 258f0001
P ad2f0008
P 8d300004
P 020f8823
P ad31000c
P 1000ffff
W 00000000 01 12340000
W 00000004 01 12345678
W 00000008 02 00000010
W 0000000c 03 12345688
W 00000010 04 00000010
W 00000014 05 ffffffff
W 00000018 06 00000001
W 0000001c 07 12345678
W 00000020 08 00000011
W 00000024 09 00000400
W 0000002c 0a 12345678
W 00000030 0b 12345688
W 0000003c 0c 00000010
W 00000050 0f 00000011
W 00000058 10 12345688
W 0000005c 11 12345677
M 100 12345678
M 101 12345688
M 102 00000011
M 103 12345677

// File: tests/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*, core_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic [XLEN-1:0]       mem_rdata;
    logic                  mem_en;
    logic                  mem_wen;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [XLEN-1:0]       mem_wdata;
    logic [XLEN-1:0]       debug_wb_pc;
    logic                  debug_wb_wen;
    logic [REG_ADDR_W-1:0] debug_wb_wnum;
    logic [XLEN-1:0]       debug_wb_wdata;

    // Memory model and the request captured in mid cycle
    logic [XLEN-1:0]       mem [2**MEM_ADDR_W];
    logic                  req_en;
    logic                  req_wen;
    logic [MEM_ADDR_W-1:0] req_addr;
    logic [XLEN-1:0]       req_wdata;
    logic [XLEN-1:0]       read_word;

    // Expected trace and memory
    logic [XLEN-1:0]       exp_wb_pc    [$];
    logic [REG_ADDR_W-1:0] exp_wb_num   [$];
    logic [XLEN-1:0]       exp_wb_data  [$];
    logic [MEM_ADDR_W-1:0] exp_mem_addr [$];
    logic [XLEN-1:0]       exp_mem_data [$];
    int                    prog_words;
    int                    num_wb;
    int                    wb_count;
    int                    cycle_count;
    int                    cycle_limit;

    cpu_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .mem_rdata      (mem_rdata),
        .mem_en         (mem_en),
        .mem_wen        (mem_wen),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .debug_wb_pc    (debug_wb_pc),
        .debug_wb_wen   (debug_wb_wen),
        .debug_wb_wnum  (debug_wb_wnum),
        .debug_wb_wdata (debug_wb_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic load_patterns();
        int                fd;
        int                code;
        int                expect_n;
        logic [63:0]       tag;
        logic [8*160-1:0]  rest;
        logic [XLEN-1:0]   f0;
        logic [XLEN-1:0]   f1;
        logic [XLEN-1:0]   f2;
        fd = $fopen("tests/cpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the pattern file tests/cpu_patterns.txt could not be opened");
            abort_run();
        end
        prog_words = 0;
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code     = $fgets(rest, fd);
                code     = 0;
                expect_n = 0;
            end else if (tag == "P") begin
                code     = $fscanf(fd, "%h", f0);
                expect_n = 1;
                mem[prog_words] = f0;
                prog_words++;
            end else if (tag == "W") begin
                code     = $fscanf(fd, "%h %h %h", f0, f1, f2);
                expect_n = 3;
                exp_wb_pc.push_back(f0);
                exp_wb_num.push_back(f1[REG_ADDR_W-1:0]);
                exp_wb_data.push_back(f2);
            end else if (tag == "M") begin
                code     = $fscanf(fd, "%h %h", f0, f1);
                expect_n = 2;
                exp_mem_addr.push_back(f0[MEM_ADDR_W-1:0]);
                exp_mem_data.push_back(f1);
            end else begin
                $display("ERROR: the pattern file holds a line with an unknown tag");
                abort_run();
            end
            if (code != expect_n) begin
                $display("ERROR: a pattern line has fewer fields than its tag needs");
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    // ======================================================================
    // Memory model with a read latency of one cycle
    // ======================================================================
    always @(negedge clk) begin
        req_en    = (mem_en === 1'b1);
        req_wen   = (mem_wen === 1'b1);
        req_addr  = mem_addr;
        req_wdata = mem_wdata;
    end

    always @(posedge clk) begin
        if (req_en && req_wen) begin
            mem[req_addr] = req_wdata;
        end else if (req_en) begin
            read_word = mem[req_addr];
        end
        #1;
        mem_rdata = read_word;
    end

    // ======================================================================
    // Writeback trace, assertion status and timeout
    // ======================================================================
    always @(negedge clk) begin
        if (u_dut.u_cpu_assert.error_count != 0) begin
            $display("ERROR: an assertion on the DUT ports failed");
            abort_run();
        end
        if (!reset && debug_wb_wen === 1'b1) begin
            if (wb_count >= num_wb) begin
                $display("ERROR: writeback from pc 0x%08h after the whole expected trace",
                         debug_wb_pc);
                abort_run();
            end else begin
                check_value("debug_wb_pc", debug_wb_pc, exp_wb_pc[wb_count]);
                check_value("debug_wb_wnum", debug_wb_wnum, exp_wb_num[wb_count]);
                check_value("debug_wb_wdata", debug_wb_wdata, exp_wb_data[wb_count]);
                wb_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("ERROR: timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycle_count, wb_count, num_wb);
            abort_run();
        end
    end

    initial begin
        reset       = 1'b1;
        mem_rdata   = '0;
        req_en      = 1'b0;
        req_wen     = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        read_word   = '0;
        wb_count    = 0;
        cycle_count = 0;
        num_wb      = 0;
        cycle_limit = 200;
        // Fill word carries its own address
        // Opcode 0x3f decodes to nothing
        for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
            mem[a] = 32'hfc00_0000 | XLEN'(a);
        end
        load_patterns();
        num_wb      = exp_wb_pc.size();
        cycle_limit = 20 * prog_words + 200;
        if (prog_words == 0 || num_wb == 0) begin
            $display("ERROR: the pattern file holds no program or no expected writebacks");
            abort_run();
        end

        // Outputs quiet once the first edge has cleared the pipeline
        repeat (15) begin
            @(negedge clk);
            check_value("mem_en", mem_en, 1'b0);
            check_value("mem_wen", mem_wen, 1'b0);
            check_value("debug_wb_wen", debug_wb_wen, 1'b0);
        end
        @(posedge clk);
        #1;
        reset = 1'b0;

        // First cycle out of reset fetches word zero
        @(negedge clk);
        check_value("mem_en", mem_en, 1'b1);
        check_value("mem_wen", mem_wen, 1'b0);
        check_value("mem_addr", mem_addr, '0);

        wait (wb_count == num_wb);
        repeat (20) @(negedge clk);

        foreach (exp_mem_addr[k]) begin
            check_value($sformatf("mem[0x%03h]", exp_mem_addr[k]), mem[exp_mem_addr[k]],
                        exp_mem_data[k]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tests/tb_cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_en,
    input  logic                  mem_wen,
    input  logic                  debug_wb_wen,
    input  logic [REG_ADDR_W-1:0] debug_wb_wnum
);

    // Failed assertions so far, read by the testbench
    int   error_count = 0;
    logic reset_d     = 1'b0;

    // Reset seen at the previous edge, so the first edge has cleared the pipeline
    always_ff @(posedge clk) begin
        reset_d <= reset;
    end

    // A write always travels with an enable
    a_wen_needs_en: assert property (
        @(posedge clk) disable iff (reset) mem_wen |-> mem_en
    ) else begin
        error_count++;
        $error("mem_wen high while mem_en is low");
    end

    a_quiet_in_reset: assert property (
        @(posedge clk) (reset && reset_d) |-> (!mem_en && !mem_wen && !debug_wb_wen)
    ) else begin
        error_count++;
        $error("bus or writeback strobe active during reset");
    end

    a_wb_not_zero: assert property (
        @(posedge clk) disable iff (reset) debug_wb_wen |-> (debug_wb_wnum != '0)
    ) else begin
        error_count++;
        $error("writeback to register zero on the debug trace");
    end

    a_wb_wen_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(debug_wb_wen)
    ) else begin
        error_count++;
        $error("debug_wb_wen is unknown after reset");
    end

endmodule

bind cpu_top cpu_assert u_cpu_assert (
    .clk           (clk),
    .reset         (reset),
    .mem_en        (mem_en),
    .mem_wen       (mem_wen),
    .debug_wb_wen  (debug_wb_wen),
    .debug_wb_wnum (debug_wb_wnum)
);

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       mem_rdata,
    output logic                  mem_en,
    output logic                  mem_wen,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic [XLEN-1:0]       mem_wdata,
    output logic [XLEN-1:0]       debug_wb_pc,
    output logic                  debug_wb_wen,
    output logic [REG_ADDR_W-1:0] debug_wb_wnum,
    output logic [XLEN-1:0]       debug_wb_wdata
);

    // Shared bus
    logic                  fetch_req;
    logic                  fetch_grant;
    logic                  fetch_ret;
    logic [MEM_ADDR_W-1:0] fetch_addr;
    logic                  data_req;
    logic                  data_wen;
    logic [MEM_ADDR_W-1:0] data_addr;
    logic [XLEN-1:0]       data_wdata;

    // Fetch slot and branch redirect
    logic                  d_valid;
    logic [XLEN-1:0]       d_pc;
    instr_t                d_instr;
    logic                  stall;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;

    // Execute stage
    logic                  e_valid;
    logic [XLEN-1:0]       e_pc;
    instr_t                e_instr;
    logic [ALU_OP_W-1:0]   e_alu_op;
    logic                  e_use_imm;
    logic [XLEN-1:0]       e_imm;
    logic [XLEN-1:0]       e_rs_val;
    logic [XLEN-1:0]       e_rt_val;
    logic [REG_ADDR_W-1:0] e_rs;
    logic [REG_ADDR_W-1:0] e_rt;
    logic [REG_ADDR_W-1:0] e_dest;
    logic                  e_reg_wen;
    logic                  e_load;
    logic                  e_store;
    logic                  e_branch_ne;
    logic                  e_branch;

    // Memory stage
    logic                  m_valid;
    logic [XLEN-1:0]       m_pc;
    logic [XLEN-1:0]       m_result;
    logic [XLEN-1:0]       m_store_data;
    logic [REG_ADDR_W-1:0] m_dest;
    logic                  m_reg_wen;
    logic                  m_load;
    logic                  m_store;
    logic                  m_fwd_wen;

    // Writeback
    logic                  w_wen;
    logic [REG_ADDR_W-1:0] w_dest;
    logic [XLEN-1:0]       w_data;
    logic [XLEN-1:0]       w_pc;

    assign debug_wb_pc    = w_pc;
    assign debug_wb_wen   = w_wen;
    assign debug_wb_wnum  = w_dest;
    assign debug_wb_wdata = w_data;

    bus_arbiter  u_bus_arbiter  (.*);
    fetch_unit   u_fetch_unit   (.*);
    decode_unit  u_decode_unit  (.*);
    execute_unit u_execute_unit (.*);
    mem_wb_unit  u_mem_wb_unit  (.*);

endmodule

// File: rtl/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  m_valid,
    input  logic [XLEN-1:0]       m_pc,
    input  logic [XLEN-1:0]       m_result,
    input  logic [XLEN-1:0]       m_store_data,
    input  logic [REG_ADDR_W-1:0] m_dest,
    input  logic                  m_reg_wen,
    input  logic                  m_load,
    input  logic                  m_store,
    input  logic [XLEN-1:0]       mem_rdata,
    output logic                  data_req,
    output logic                  data_wen,
    output logic [MEM_ADDR_W-1:0] data_addr,
    output logic [XLEN-1:0]       data_wdata,
    output logic                  m_fwd_wen,
    output logic                  w_wen,
    output logic [REG_ADDR_W-1:0] w_dest,
    output logic [XLEN-1:0]       w_data,
    output logic [XLEN-1:0]       w_pc
);

    logic            w_load;
    logic [XLEN-1:0] w_result;

    // Word access, the two low address bits are dropped
    assign data_req   = m_valid && (m_load || m_store);
    assign data_wen   = m_store;
    assign data_addr  = m_result[MEM_ADDR_W+1:2];
    assign data_wdata = m_store_data;

    // Load data only exists one stage later
    assign m_fwd_wen = m_valid && m_reg_wen && !m_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            w_wen  <= 1'b0;
            w_load <= 1'b0;
        end else begin
            w_wen  <= m_valid && m_reg_wen;
            w_load <= m_valid && m_load;
        end
    end

    always_ff @(posedge clk) begin
        w_pc     <= m_pc;
        w_dest   <= m_dest;
        w_result <= m_result;
    end

    assign w_data = w_load ? mem_rdata : w_result;

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  e_valid,
    input  logic [XLEN-1:0]       e_pc,
    input  instr_t                e_instr,
    input  logic [ALU_OP_W-1:0]   e_alu_op,
    input  logic                  e_use_imm,
    input  logic [XLEN-1:0]       e_imm,
    input  logic [XLEN-1:0]       e_rs_val,
    input  logic [XLEN-1:0]       e_rt_val,
    input  logic [REG_ADDR_W-1:0] e_rs,
    input  logic [REG_ADDR_W-1:0] e_rt,
    input  logic [REG_ADDR_W-1:0] e_dest,
    input  logic                  e_reg_wen,
    input  logic                  e_load,
    input  logic                  e_store,
    input  logic                  e_branch_ne,
    input  logic                  e_branch,
    input  logic                  m_fwd_wen,
    input  logic                  w_wen,
    input  logic [REG_ADDR_W-1:0] w_dest,
    input  logic [XLEN-1:0]       w_data,
    output logic                  redirect,
    output logic [XLEN-1:0]       redirect_pc,
    output logic                  m_valid,
    output logic [XLEN-1:0]       m_pc,
    output logic [XLEN-1:0]       m_result,
    output logic [XLEN-1:0]       m_store_data,
    output logic [REG_ADDR_W-1:0] m_dest,
    output logic                  m_reg_wen,
    output logic                  m_load,
    output logic                  m_store
);

    logic [XLEN-1:0] rs_op;
    logic [XLEN-1:0] rt_op;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] offset;

    // Memory stage first, then writeback, then the register file copy
    assign rs_op = (m_fwd_wen && (m_dest == e_rs)) ? m_result :
                   (w_wen && (w_dest == e_rs))     ? w_data   : e_rs_val;
    assign rt_op = (m_fwd_wen && (m_dest == e_rt)) ? m_result :
                   (w_wen && (w_dest == e_rt))     ? w_data   : e_rt_val;

    assign src_b = e_use_imm ? e_imm : rt_op;

    always_comb begin
        case (e_alu_op)
            ALU_SUB: alu_out = rs_op - src_b;
            ALU_AND: alu_out = rs_op & src_b;
            ALU_OR:  alu_out = rs_op | src_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(rs_op) < $signed(src_b)};
            ALU_LUI: alu_out = src_b;
            default: alu_out = rs_op + src_b;
        endcase
    end

    // Branch resolves here, target is pc+4 plus the word offset
    assign offset      = {{(XLEN-18){e_instr.i.imm16[15]}}, e_instr.i.imm16, 2'b00};
    assign redirect    = e_branch && ((rs_op == rt_op) != e_branch_ne);
    assign redirect_pc = e_pc + XLEN'(4) + offset;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid   <= 1'b0;
            m_reg_wen <= 1'b0;
            m_load    <= 1'b0;
            m_store   <= 1'b0;
        end else begin
            m_valid   <= e_valid;
            m_reg_wen <= e_reg_wen;
            m_load    <= e_load;
            m_store   <= e_store;
        end
    end

    always_ff @(posedge clk) begin
        m_pc         <= e_pc;
        m_result     <= alu_out;
        m_store_data <= rt_op;
        m_dest       <= e_dest;
    end

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  d_valid,
    input  logic [XLEN-1:0]       d_pc,
    input  instr_t                d_instr,
    input  logic                  redirect,
    input  logic                  w_wen,
    input  logic [REG_ADDR_W-1:0] w_dest,
    input  logic [XLEN-1:0]       w_data,
    output logic                  stall,
    output logic                  e_valid,
    output logic [XLEN-1:0]       e_pc,
    output instr_t                e_instr,
    output logic [ALU_OP_W-1:0]   e_alu_op,
    output logic                  e_use_imm,
    output logic [XLEN-1:0]       e_imm,
    output logic [XLEN-1:0]       e_rs_val,
    output logic [XLEN-1:0]       e_rt_val,
    output logic [REG_ADDR_W-1:0] e_rs,
    output logic [REG_ADDR_W-1:0] e_rt,
    output logic [REG_ADDR_W-1:0] e_dest,
    output logic                  e_reg_wen,
    output logic                  e_load,
    output logic                  e_store,
    output logic                  e_branch_ne,
    output logic                  e_branch
);

    logic [ALU_OP_W-1:0]   alu_op;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] dest;
    logic                  use_imm;
    logic                  writes;
    logic                  reg_wen;
    logic                  load;
    logic                  store;
    logic                  branch;
    logic                  branch_ne;
    logic                  advance;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;

    // ======================================================================
    // Instruction decode
    // ======================================================================
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b1;
        imm       = {{16{d_instr.i.imm16[15]}}, d_instr.i.imm16};
        dest      = d_instr.i.rt;
        writes    = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        case (d_instr.i.op)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dest    = d_instr.r.rd;
                writes  = 1'b1;
                case (d_instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: writes = 1'b1;
            OP_ORI: begin
                alu_op = ALU_OR;
                imm    = {16'h0000, d_instr.i.imm16};
                writes = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                imm    = {d_instr.i.imm16, 16'h0000};
                writes = 1'b1;
            end
            OP_LW: begin
                load   = 1'b1;
                writes = 1'b1;
            end
            OP_SW:  store = 1'b1;
            OP_BEQ: branch = 1'b1;
            OP_BNE: begin
                branch    = 1'b1;
                branch_ne = 1'b1;
            end
            default: ;
        endcase
    end

    // Register zero is never a real destination
    assign reg_wen = writes && (dest != '0);

    // Load in execute feeding either source field here
    assign stall = d_valid && e_load && e_reg_wen &&
                   ((e_dest == d_instr.r.rs) || (e_dest == d_instr.r.rt));

    assign advance = d_valid && !stall && !redirect;

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs     (d_instr.r.rs),
        .rt     (d_instr.r.rt),
        .w_wen  (w_wen),
        .w_dest (w_dest),
        .w_data (w_data),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    // ======================================================================
    // Decode/execute register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid   <= 1'b0;
            e_reg_wen <= 1'b0;
            e_load    <= 1'b0;
            e_store   <= 1'b0;
            e_branch  <= 1'b0;
        end else begin
            // Bubble on stall, redirect or an empty slot
            e_valid   <= advance;
            e_reg_wen <= advance && reg_wen;
            e_load    <= advance && load;
            e_store   <= advance && store;
            e_branch  <= advance && branch;
        end
    end

    always_ff @(posedge clk) begin
        e_pc        <= d_pc;
        e_instr     <= d_instr;
        e_alu_op    <= alu_op;
        e_use_imm   <= use_imm;
        e_imm       <= imm;
        e_rs_val    <= rs_val;
        e_rt_val    <= rt_val;
        e_rs        <= d_instr.r.rs;
        e_rt        <= d_instr.r.rt;
        e_dest      <= dest;
        e_branch_ne <= branch_ne;
    end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_grant,
    input  logic                  fetch_ret,
    input  logic [XLEN-1:0]       mem_rdata,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [XLEN-1:0]       redirect_pc,
    output logic                  fetch_req,
    output logic [MEM_ADDR_W-1:0] fetch_addr,
    output logic                  d_valid,
    output logic [XLEN-1:0]       d_pc,
    output instr_t                d_instr
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] flight_pc;
    logic            issue;
    logic            hold_valid;
    logic [XLEN-1:0] hold_pc;
    instr_t          hold_instr;

    // Nothing issues on a redirect or while decode keeps its slot
    assign fetch_req  = !redirect && !(d_valid && stall);
    assign fetch_addr = pc[MEM_ADDR_W+1:2];
    assign issue      = fetch_req && fetch_grant;

    assign d_valid = fetch_ret || hold_valid;
    assign d_pc    = hold_valid ? hold_pc : flight_pc;
    assign d_instr = hold_valid ? hold_instr : instr_t'(mem_rdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= RESET_PC;
            hold_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (issue) begin
                pc <= pc + XLEN'(4);
            end
            // Word parked while decode stalls, dropped on a redirect
            hold_valid <= d_valid && stall && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            flight_pc <= pc;
        end
        if (d_valid && stall) begin
            hold_pc    <= d_pc;
            hold_instr <= d_instr;
        end
    end

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  data_req,
    input  logic                  data_wen,
    input  logic [MEM_ADDR_W-1:0] data_addr,
    input  logic [XLEN-1:0]       data_wdata,
    input  logic                  fetch_req,
    input  logic [MEM_ADDR_W-1:0] fetch_addr,
    output logic                  fetch_grant,
    output logic                  fetch_ret,
    output logic                  mem_en,
    output logic                  mem_wen,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic [XLEN-1:0]       mem_wdata
);

    // Set when the read now on the bus came from fetch
    logic fetch_owner;

    // Memory stage always wins, and the bus stays idle in reset
    assign fetch_grant = !reset && !data_req;

    assign mem_en    = data_req || (fetch_req && fetch_grant);
    assign mem_wen   = data_req && data_wen;
    assign mem_addr  = data_req ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_owner <= 1'b0;
        end else begin
            fetch_owner <= fetch_req && fetch_grant;
        end
    end

    // Read data returns one cycle after the request
    assign fetch_ret = fetch_owner;

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs,
    input  logic [REG_ADDR_W-1:0] rt,
    input  logic                  w_wen,
    input  logic [REG_ADDR_W-1:0] w_dest,
    input  logic [XLEN-1:0]       w_data,
    output logic [XLEN-1:0]       rs_val,
    output logic [XLEN-1:0]       rt_val
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else if (w_wen && (w_dest != '0)) begin
            regs[w_dest] <= w_data;
        end
    end

    // A write in this cycle is seen by the readers at once
    assign rs_val = (rs == '0) ? '0 : (w_wen && (w_dest == rs)) ? w_data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (w_wen && (w_dest == rt)) ? w_data : regs[rt];

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    // Shared memory, word addressed
    localparam int MEM_ADDR_W = 12;

    // First fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // ======================================================================
    // ALU operation codes
    // ======================================================================
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;
    // Passes operand B, which decode has already shifted up
    localparam logic [ALU_OP_W-1:0] ALU_LUI = 3'd5;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // ======================================================================
    // Primary opcodes
    // ======================================================================
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // Function field of the SPECIAL group
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // One instruction word, seen as R format or as I format
    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm16;
        } i;
    } instr_t;

endpackage
